//--- rtl/capture_pkg.sv
package capture_pkg;

  //////////////////////////////
  // frame geometry
  //////////////////////////////

  // scaled-down frame, 16 x 8 pixels
  localparam int FRAME_W      = 16;
  localparam int FRAME_H      = 8;
  localparam int FRAME_PIXELS = FRAME_W * FRAME_H;

  // enough address bits to cover the whole frame
  localparam int ADDR_W = $clog2(FRAME_PIXELS);

  //////////////////////////////
  // pixel and address types
  //////////////////////////////

  // rgb332 layout
  // red 7..5, green 4..2, blue 1..0
  typedef logic [7:0] pixel_t;

  typedef logic [ADDR_W-1:0] pixel_addr_t;

  // main controller states
  typedef enum logic [1:0] {
    CAP_IDLE  = 2'd0,
    CAP_STORE = 2'd1,
    CAP_SEND  = 2'd2,
    CAP_DRAIN = 2'd3
  } capture_state_e;

endpackage

//--- rtl/uart_pkg.sv
package uart_pkg;

  //////////////////////////////
  // serial bit timing
  //////////////////////////////

  // short divider so the serial frames stay short in simulation
  localparam int CLKS_PER_BIT = 4;
  localparam int DATA_BITS    = 8;

  // start + data + stop
  localparam int FRAME_BITS = DATA_BITS + 2;

  // baud timer and bit index widths
  localparam int BAUD_CNT_W = $clog2(CLKS_PER_BIT);
  localparam int BIT_IDX_W  = $clog2(FRAME_BITS);

  typedef logic [DATA_BITS-1:0] uart_byte_t;

  // byte order on the wire, green first
  typedef enum logic [1:0] {
    CH_GREEN = 2'd0,
    CH_BLUE  = 2'd1,
    CH_RED   = 2'd2
  } tx_channel_e;

endpackage

//--- rtl/capture_fsm.sv
`timescale 1ns/100ps

module capture_fsm import capture_pkg::*; (
  input  logic           clk,
  input  logic           uart_reset,
  input  logic           store_req,
  input  logic           send_req,
  input  logic           pixel_valid,
  input  logic           frame_last,
  input  logic           pixel_advance,
  input  logic           tx_busy,
  output capture_state_e state,
  output logic           count_clear,
  output logic           store_write,
  output logic           send_done,
  output logic           capture_busy
);

  capture_state_e state_next;

  //////////////////////////////
  // state register
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (uart_reset) begin
      state <= CAP_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // next state
  // requests only count in idle, store has priority
  always_comb begin
    state_next = state;
    case (state)
      CAP_IDLE: begin
        if (store_req) begin
          state_next = CAP_STORE;
        end else if (send_req) begin
          state_next = CAP_SEND;
        end
      end
      CAP_STORE: begin
        // last write of the frame ends the capture
        if (store_write && frame_last) begin
          state_next = CAP_IDLE;
        end
      end
      CAP_SEND: begin
        // red byte of the final pixel has been started
        if (pixel_advance && frame_last) begin
          state_next = CAP_DRAIN;
        end
      end
      CAP_DRAIN: begin
        // wait out the final stop bit
        if (!tx_busy) begin
          state_next = CAP_IDLE;
        end
      end
      default: state_next = CAP_IDLE;
    endcase
  end

  //////////////////////////////
  // strobes
  //////////////////////////////

  // address reset on every exit from idle
  assign count_clear  = (state == CAP_IDLE) && (store_req || send_req);

  // pixel_valid ignored outside store
  assign store_write  = (state == CAP_STORE) && pixel_valid;

  // one cycle, the cycle after the last stop bit
  assign send_done    = (state == CAP_DRAIN) && !tx_busy;

  assign capture_busy = (state != CAP_IDLE);

endmodule

//--- rtl/pixel_counter.sv
`timescale 1ns/100ps

module pixel_counter import capture_pkg::*; (
  input  logic        clk,
  input  logic        uart_reset,
  input  logic        count_clear,
  input  logic        store_write,
  input  logic        pixel_advance,
  output pixel_addr_t addr,
  output logic        frame_last
);

  // final address of the frame
  localparam pixel_addr_t LAST_ADDR = pixel_addr_t'(FRAME_PIXELS - 1);

  //////////////////////////////
  // frame address
  //////////////////////////////

  // store and send never advance together,
  // either strobe moves to the next pixel
  always_ff @(posedge clk) begin
    if (uart_reset) begin
      addr <= '0;
    end else if (count_clear) begin
      addr <= '0;
    end else if (store_write || pixel_advance) begin
      addr <= addr + 1'b1;
    end
  end

  // high for as long as the last pixel is addressed
  assign frame_last = (addr == LAST_ADDR);

endmodule

//--- rtl/frame_buffer.sv
`timescale 1ns/100ps

module frame_buffer import capture_pkg::*; (
  input  logic        clk,
  input  logic        store_write,
  input  pixel_addr_t addr,
  input  pixel_t      pixel_in,
  output pixel_t      pixel_out
);

  // one pixel per address, whole frame
  pixel_t mem [FRAME_PIXELS];

  //////////////////////////////
  // write port
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (store_write) begin
      mem[addr] <= pixel_in;
    end
  end

  //////////////////////////////
  // read port
  //////////////////////////////

  // registered read, data one cycle after the address
  // a same-cycle write returns the old word
  always_ff @(posedge clk) begin
    pixel_out <= mem[addr];
  end

endmodule

//--- rtl/rgb_byte_sequencer.sv
`timescale 1ns/100ps

module rgb_byte_sequencer
  import capture_pkg::*;
  import uart_pkg::*;
(
  input  logic           clk,
  input  logic           uart_reset,
  input  capture_state_e state,
  input  logic           count_clear,
  input  logic           tx_busy,
  input  pixel_t         pixel_out,
  output logic           tx_start,
  output logic           pixel_advance,
  output uart_byte_t     tx_data
);

  tx_channel_e channel;

  // read data not yet valid after an address change
  logic read_wait;

  // start issued on the previous cycle
  logic start_q;

  //////////////////////////////
  // start and advance
  //////////////////////////////

  // one byte per channel, only while sending
  assign tx_start = (state == CAP_SEND) && !read_wait && !tx_busy && !start_q;

  // red closes the pixel
  assign pixel_advance = tx_start && (channel == CH_RED);

  always_ff @(posedge clk) begin
    if (uart_reset) begin
      read_wait <= 1'b0;
      start_q   <= 1'b0;
    end else begin
      // covers the one-cycle read latency
      read_wait <= count_clear || pixel_advance;
      start_q   <= tx_start;
    end
  end

  //////////////////////////////
  // channel walk
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (uart_reset) begin
      channel <= CH_GREEN;
    end else if (count_clear) begin
      channel <= CH_GREEN;
    end else if (tx_start) begin
      case (channel)
        CH_GREEN: channel <= CH_BLUE;
        CH_BLUE:  channel <= CH_RED;
        default:  channel <= CH_GREEN;
      endcase
    end
  end

  // byte format
  // channel bits moved to the top, zeros below
  always_comb begin
    case (channel)
      CH_GREEN: tx_data = {pixel_out[4:2], 5'b0};
      CH_BLUE:  tx_data = {pixel_out[1:0], 6'b0};
      CH_RED:   tx_data = {pixel_out[7:5], 5'b0};
      default:  tx_data = '0;
    endcase
  end

endmodule

//--- rtl/uart_tx.sv
`timescale 1ns/100ps

module uart_tx import uart_pkg::*; (
  input  logic       clk,
  input  logic       uart_reset,
  input  logic       tx_start,
  input  uart_byte_t tx_data,
  output logic       txd,
  output logic       tx_busy
);

  localparam logic [BAUD_CNT_W-1:0] BAUD_LAST = BAUD_CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [BIT_IDX_W-1:0]  STOP_IDX  = BIT_IDX_W'(DATA_BITS);
  localparam logic [BIT_IDX_W-1:0]  LAST_IDX  = BIT_IDX_W'(FRAME_BITS - 1);

  logic [BAUD_CNT_W-1:0] baud_cnt;

  // 0 start, 1..8 data, 9 stop
  logic [BIT_IDX_W-1:0]  bit_idx;

  uart_byte_t shift_q;

  // a start only counts while idle
  logic accept;
  logic bit_end;

  assign accept  = tx_start && !tx_busy;
  assign bit_end = tx_busy && (baud_cnt == BAUD_LAST);

  //////////////////////////////
  // line and timers
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (uart_reset) begin
      txd      <= 1'b1;
      tx_busy  <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
    end else if (accept) begin
      // start bit from the next cycle
      txd      <= 1'b0;
      tx_busy  <= 1'b1;
      baud_cnt <= '0;
      bit_idx  <= '0;
    end else if (tx_busy) begin
      baud_cnt <= baud_cnt + 1'b1;
      if (bit_end) begin
        baud_cnt <= '0;
        bit_idx  <= bit_idx + 1'b1;
        if (bit_idx == LAST_IDX) begin
          // stop bit done, line already high
          tx_busy <= 1'b0;
          bit_idx <= '0;
        end else if (bit_idx == STOP_IDX) begin
          txd <= 1'b1;
        end else begin
          // lsb first
          txd <= shift_q[0];
        end
      end
    end
  end

  // data shifter
  always_ff @(posedge clk) begin
    if (accept) begin
      shift_q <= tx_data;
    end else if (bit_end && (bit_idx < STOP_IDX)) begin
      shift_q <= shift_q >> 1;
    end
  end

endmodule

//--- rtl/frame_uart_top.sv
`timescale 1ns/100ps

module frame_uart_top
  import capture_pkg::*;
  import uart_pkg::*;
(
  input  logic   clk,
  input  logic   uart_reset,
  input  logic   store_req,
  input  logic   send_req,
  input  pixel_t pixel_in,
  input  logic   pixel_valid,
  output logic   txd,
  output logic   capture_busy,
  output logic   send_done
);

  capture_state_e state;
  logic           count_clear;
  logic           store_write;
  logic           pixel_advance;
  logic           frame_last;
  logic           tx_start;
  logic           tx_busy;
  pixel_addr_t    addr;
  pixel_t         pixel_out;
  uart_byte_t     tx_data;

  //////////////////////////////
  // control
  //////////////////////////////

  capture_fsm u_capture_fsm (
    .clk           (clk),
    .uart_reset    (uart_reset),
    .store_req     (store_req),
    .send_req      (send_req),
    .pixel_valid   (pixel_valid),
    .frame_last    (frame_last),
    .pixel_advance (pixel_advance),
    .tx_busy       (tx_busy),
    .state         (state),
    .count_clear   (count_clear),
    .store_write   (store_write),
    .send_done     (send_done),
    .capture_busy  (capture_busy)
  );

  // shared address for capture and readback
  pixel_counter u_pixel_counter (
    .clk           (clk),
    .uart_reset    (uart_reset),
    .count_clear   (count_clear),
    .store_write   (store_write),
    .pixel_advance (pixel_advance),
    .addr          (addr),
    .frame_last    (frame_last)
  );

  //////////////////////////////
  // datapath
  //////////////////////////////

  frame_buffer u_frame_buffer (
    .clk         (clk),
    .store_write (store_write),
    .addr        (addr),
    .pixel_in    (pixel_in),
    .pixel_out   (pixel_out)
  );

  // three bytes per pixel, g b r
  rgb_byte_sequencer u_rgb_byte_sequencer (
    .clk           (clk),
    .uart_reset    (uart_reset),
    .state         (state),
    .count_clear   (count_clear),
    .tx_busy       (tx_busy),
    .pixel_out     (pixel_out),
    .tx_start      (tx_start),
    .pixel_advance (pixel_advance),
    .tx_data       (tx_data)
  );

  uart_tx u_uart_tx (
    .clk        (clk),
    .uart_reset (uart_reset),
    .tx_start   (tx_start),
    .tx_data    (tx_data),
    .txd        (txd),
    .tx_busy    (tx_busy)
  );

endmodule

//--- sim/frame_uart_props.sv
`timescale 1ns/100ps

module frame_uart_props import uart_pkg::*; (
  input logic clk,
  input logic uart_reset,
  input logic tx_start,
  input logic txd,
  input logic tx_busy,
  input logic send_done,
  input logic capture_busy
);

  // idle line sits at the stop level
  idle_line_high: assert property (
    @(posedge clk) disable iff (uart_reset) !tx_busy |-> txd
  ) else $error("txd low while the transmitter is idle");

  // accepted start holds busy for one whole serial frame
  // start bit low first, stop bit high last
  start_sets_busy: assert property (
    @(posedge clk) disable iff (uart_reset)
      (tx_start && !tx_busy) |=> (tx_busy && !txd)
        ##(FRAME_BITS * CLKS_PER_BIT - 1) (tx_busy && txd) ##1 !tx_busy
  ) else $error("tx_start accepted but the serial frame timing is wrong");

  // done only right after the last stop bit
  // one cycle wide with the controller back in idle
  done_single_cycle: assert property (
    @(posedge clk) disable iff (uart_reset)
      send_done |-> $past(tx_busy) ##1 (!send_done && !capture_busy)
  ) else $error("send_done not after the stop bit, too long or capture_busy still high");

endmodule

//////////////////////////////
// bind into the design
//////////////////////////////

// transmitter instance with the controller inputs tied low
bind uart_tx frame_uart_props u_tx_props (
  .clk          (clk),
  .uart_reset   (uart_reset),
  .tx_start     (tx_start),
  .txd          (txd),
  .tx_busy      (tx_busy),
  .send_done    (1'b0),
  .capture_busy (1'b0)
);

// controller instance with the line tied to its idle level
bind capture_fsm frame_uart_props u_fsm_props (
  .clk          (clk),
  .uart_reset   (uart_reset),
  .tx_start     (1'b0),
  .txd          (1'b1),
  .tx_busy      (tx_busy),
  .send_done    (send_done),
  .capture_busy (capture_busy)
);

//--- sim/frame_uart_tb.sv
`timescale 1ns/100ps

module frame_uart_tb
  import capture_pkg::*;
  import uart_pkg::*;
;

  localparam int TIMEOUT_CYCLES = 40000;
  localparam int RESET_CYCLES   = 4;
  localparam int IGNORED_CYCLES = 150;

  logic   clk;
  logic   uart_reset;
  logic   store_req;
  logic   send_req;
  pixel_t pixel_in;
  logic   pixel_valid;
  logic   txd;
  logic   capture_busy;
  logic   send_done;

  // frame as it was stored, address order
  pixel_t ref_pixels [FRAME_PIXELS];
  logic   done_allowed;
  int     done_pulses = 0;
  int     cycle_cnt = 0;

  frame_uart_top dut (
    .clk          (clk),
    .uart_reset   (uart_reset),
    .store_req    (store_req),
    .send_req     (send_req),
    .pixel_in     (pixel_in),
    .pixel_valid  (pixel_valid),
    .txd          (txd),
    .capture_busy (capture_busy),
    .send_done    (send_done)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////
  // error reporting
  //////////////////////////////

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("[ERROR] %s expected 0x%0h actual 0x%0h", name, expected, actual);
    $display("Verification failed");
    $fatal(1);
  endtask

  // watchdog
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      report_failure("simulation timed out before all tests finished");
    end
  end

  // done pulses seen on the port
  always @(negedge clk) begin
    if (send_done) begin
      done_pulses <= done_pulses + 1;
    end
  end

  // outputs quiet one cycle after any reset
  reset_idle: assert property (
    @(posedge clk) uart_reset |=> (txd && !capture_busy && !send_done)
  ) else report_failure("outputs not idle in the cycle after reset");

  // no completion unless a full send is running
  done_expected: assert property (
    @(posedge clk) disable iff (uart_reset) send_done |-> done_allowed
  ) else report_failure("send_done pulsed outside a completed send");

  //////////////////////////////
  // reference model
  //////////////////////////////

  // channel bits to the top of the byte, zero fill
  function automatic uart_byte_t channel_byte(input pixel_t p, input int ch);
    case (ch)
      0: return (p & 8'h1c) << 3;
      1: return (p & 8'h03) << 6;
      default: return p & 8'he0;
    endcase
  endfunction

  // uart receiver, samples at bit centres on the falling clock
  task automatic receive_byte(output uart_byte_t b);
    while (txd) @(negedge clk);
    repeat (CLKS_PER_BIT / 2) @(negedge clk);
    assert (!txd) else report_failure("start bit not low at its centre");
    for (int n = 0; n < DATA_BITS; n++) begin
      repeat (CLKS_PER_BIT) @(negedge clk);
      b[n] = txd;
    end
    repeat (CLKS_PER_BIT) @(negedge clk);
    assert (txd) else report_failure("stop bit not high at its centre");
  endtask

  // whole frame, green blue red per pixel
  task automatic receive_frame();
    uart_byte_t b;
    uart_byte_t exp_b;
    for (int i = 0; i < FRAME_PIXELS; i++) begin
      for (int ch = 0; ch < 3; ch++) begin
        receive_byte(b);
        exp_b = channel_byte(ref_pixels[i], ch);
        assert (b == exp_b) else report_mismatch($sformatf("txd byte %0d", 3 * i + ch),
                                                 32'(exp_b), 32'(b));
      end
    end
  endtask

  //////////////////////////////
  // stimulus
  //////////////////////////////

  task automatic store_frame();
    @(negedge clk);
    store_req = 1'b1;
    @(negedge clk);
    store_req = 1'b0;
    assert (capture_busy) else report_failure("capture_busy low after store_req");
    for (int i = 0; i < FRAME_PIXELS; i++) begin
      // random gap before each pixel
      repeat ($urandom_range(3, 0)) @(negedge clk);
      ref_pixels[i] = pixel_t'($urandom);
      pixel_in      = ref_pixels[i];
      pixel_valid   = 1'b1;
      @(negedge clk);
      pixel_valid   = 1'b0;
    end
    assert (!capture_busy) else report_mismatch("capture_busy", 32'd0, 32'(capture_busy));
  endtask

  // requests and pixels that a running send must ignore
  task automatic inject_ignored_inputs();
    repeat (IGNORED_CYCLES) begin
      @(negedge clk);
      pixel_in    = pixel_t'($urandom);
      pixel_valid = 1'($urandom_range(1, 0));
      store_req   = ($urandom_range(7, 0) == 0);
    end
    @(negedge clk);
    pixel_valid = 1'b0;
    store_req   = 1'b0;
  endtask

  task automatic send_and_check(input bit disturb);
    int done_before;
    done_before  = done_pulses;
    done_allowed = 1'b1;
    @(negedge clk);
    send_req = 1'b1;
    @(negedge clk);
    send_req = 1'b0;
    assert (capture_busy) else report_failure("capture_busy low after send_req");
    fork
      receive_frame();
      if (disturb) inject_ignored_inputs();
    join
    // one cycle after the final stop bit
    repeat (CLKS_PER_BIT / 2) @(negedge clk);
    assert (send_done) else report_mismatch("send_done", 32'd1, 32'(send_done));
    @(negedge clk);
    assert (!capture_busy) else report_mismatch("capture_busy", 32'd0, 32'(capture_busy));
    // nothing more on the line
    repeat (4 * FRAME_BITS * CLKS_PER_BIT) begin
      @(negedge clk);
      assert (txd) else report_failure("extra byte on txd after the frame");
    end
    assert (done_pulses == done_before + 1)
      else report_mismatch("send_done pulses", 32'(done_before + 1), 32'(done_pulses));
    done_allowed = 1'b0;
  endtask

  // abort a send part way through
  task automatic reset_during_send();
    int done_before;
    done_before = done_pulses;
    @(negedge clk);
    send_req = 1'b1;
    @(negedge clk);
    send_req = 1'b0;
    repeat ($urandom_range(600, 200)) @(negedge clk);
    uart_reset = 1'b1;
    @(negedge clk);
    assert (txd) else report_mismatch("txd", 32'd1, 32'(txd));
    assert (!capture_busy) else report_mismatch("capture_busy", 32'd0, 32'(capture_busy));
    uart_reset = 1'b0;
    repeat (2 * FRAME_BITS * CLKS_PER_BIT) @(negedge clk);
    assert (done_pulses == done_before)
      else report_mismatch("send_done pulses", 32'(done_before), 32'(done_pulses));
  endtask

  initial begin
    void'($urandom(32'ha9c2));
    uart_reset   = 1'b1;
    store_req    = 1'b0;
    send_req     = 1'b0;
    pixel_in     = '0;
    pixel_valid  = 1'b0;
    done_allowed = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    uart_reset = 1'b0;
    assert (txd) else report_mismatch("txd", 32'd1, 32'(txd));
    assert (!capture_busy) else report_mismatch("capture_busy", 32'd0, 32'(capture_busy));
    assert (!send_done) else report_mismatch("send_done", 32'd0, 32'(send_done));
    store_frame();
    // first send with noise, second must match it
    send_and_check(1'b1);
    send_and_check(1'b0);
    reset_during_send();
    $display("Verification passed");
    $finish;
  end

endmodule

//--- all.f
rtl/capture_pkg.sv
rtl/uart_pkg.sv
rtl/capture_fsm.sv
rtl/pixel_counter.sv
rtl/frame_buffer.sv
rtl/rgb_byte_sequencer.sv
rtl/uart_tx.sv
rtl/frame_uart_top.sv
sim/frame_uart_props.sv
sim/frame_uart_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

# build with assertions and timing control enabled
verilator --binary --timing --assert -f all.f --top-module frame_uart_tb -o frame_uart_sim

# run and look for the pass line in the output
if ./obj_dir/frame_uart_sim | tee /dev/stderr | grep "Verification passed" > /dev/null; then
  echo "simulation run ok"
else
  echo "simulation run not ok"
  exit 1
fi
